// File: include/skin_consts.svh
`ifndef SKIN_CONSTS_SVH
`define SKIN_CONSTS_SVH

// Pixel channel and channel sum widths
`define SKIN_CHAN_W 10
`define SKIN_SUM_W 12

// Fixed point format, Q12
`define SKIN_FRAC 12

// Unsigned r or g, 0 up to 4096
`define SKIN_CHROMA_W 13

// Signed intermediate for products and sums
`define SKIN_FIX_W 32

// Output queue depth, also the credits upstream starts with
`define SKIN_QUEUE_DEPTH 4
`define SKIN_CREDIT_W 3

// Upper bound f1(r) = A*r^2 + B*r + C
`define SKIN_F1_A (-5636)
`define SKIN_F1_B 4400
`define SKIN_F1_C 10240

// Lower bound f2(r)
`define SKIN_F2_A (-3178)
`define SKIN_F2_B 2294
`define SKIN_F2_C 737

// Distance from white, w = r^2 + g^2 + K*(r+g) + C
`define SKIN_W_K (-2703)
`define SKIN_W_C 892

// w must be strictly above this
`define SKIN_W_MIN 4

`endif

// File: logic/pixel_pkg.sv
`default_nettype none

`include "skin_consts.svh"

package pixel_pkg;

    // One colour channel
    typedef logic [`SKIN_CHAN_W-1:0] chan_t;

    // RGB pixel, red in the top bits
    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } pixel_t;

endpackage

`default_nettype wire

// File: logic/chroma_pkg.sv
`default_nettype none

`include "skin_consts.svh"

package chroma_pkg;

    import pixel_pkg::*;

    // Unsigned Q12 chromaticity, 4096 means 1.0
    typedef logic [`SKIN_CHROMA_W-1:0] chroma_t;

    // Signed Q12 intermediate
    typedef logic signed [`SKIN_FIX_W-1:0] fix_t;

    // Divider result
    typedef struct packed {
        logic    valid;
        pixel_t  pixel;
        chroma_t r;
        chroma_t g;
    } chroma_stage_t;

    // First classifier stage, every product already shifted back to Q12
    typedef struct packed {
        logic    valid;
        pixel_t  pixel;
        chroma_t r;
        chroma_t g;
        fix_t    r2;
        fix_t    g2;
        fix_t    r_lin1;
        fix_t    r_lin2;
        fix_t    rg_lin;
    } class_stage_t;

endpackage

`default_nettype wire

// File: logic/chroma_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "skin_consts.svh"

module chroma_divider
    import pixel_pkg::*;
    import chroma_pkg::*;
(
    input  wire           iCLK,
    input  wire           iRST_N,
    input  wire pixel_t   pix_in,
    input  wire           pix_in_valid,
    output chroma_stage_t stage_out
);

    localparam int SUM_W = `SKIN_SUM_W;
    localparam int Q_W   = `SKIN_CHROMA_W;

    // Working state of one quotient stage
    typedef struct packed {
        pixel_t           pixel;
        logic [SUM_W-1:0] sum;
        logic [SUM_W-1:0] rem_r;
        logic [SUM_W-1:0] rem_g;
        chroma_t          q_r;
        chroma_t          q_g;
    } div_stage_t;

    // Intake registers
    logic             in_valid;
    pixel_t           in_pix;
    logic [SUM_W-1:0] in_sum;

    // Stage inputs and stage registers
    div_stage_t       src [Q_W];
    logic [Q_W-1:0]   src_valid;
    div_stage_t       stg [Q_W];
    logic [Q_W-1:0]   stg_valid;

    // One restoring step, returns {quotient bit, new remainder}
    // The first step compares without a shift since R <= S
    function automatic logic [SUM_W:0] div_step(
        input logic [SUM_W-1:0] rem,
        input logic [SUM_W-1:0] sum,
        input logic             first
    );
        logic [SUM_W:0]   trial;
        logic             take;
        logic [SUM_W-1:0] next_rem;
        trial    = first ? {1'b0, rem} : {rem, 1'b0};
        // zero sum never takes, so both quotients stay zero
        take     = (sum != '0) && (trial >= {1'b0, sum});
        next_rem = take ? SUM_W'(trial - {1'b0, sum}) : SUM_W'(trial);
        return {take, next_rem};
    endfunction

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= pix_in_valid;
        end
    end

    // Channel sum, at most 3069 so it fits without overflow
    always_ff @(posedge iCLK) begin
        in_pix <= pix_in;
        in_sum <= SUM_W'(pix_in.red) + SUM_W'(pix_in.green) + SUM_W'(pix_in.blue);
    end

    // Remainders start as the raw channel values
    assign src[0] = '{
        pixel: in_pix,
        sum:   in_sum,
        rem_r: SUM_W'(in_pix.red),
        rem_g: SUM_W'(in_pix.green),
        q_r:   '0,
        q_g:   '0
    };
    assign src_valid[0] = in_valid;

    for (genvar k = 0; k < Q_W; k++) begin : g_stage
        logic [SUM_W:0] step_r;
        logic [SUM_W:0] step_g;

        if (k > 0) begin : g_link
            assign src[k]       = stg[k-1];
            assign src_valid[k] = stg_valid[k-1];
        end

        assign step_r = div_step(src[k].rem_r, src[k].sum, k == 0);
        assign step_g = div_step(src[k].rem_g, src[k].sum, k == 0);

        always_ff @(posedge iCLK or negedge iRST_N) begin
            if (!iRST_N) begin
                stg_valid[k] <= 1'b0;
            end else begin
                stg_valid[k] <= src_valid[k];
            end
        end

        // Quotient bits enter from the right, MSB first
        always_ff @(posedge iCLK) begin
            stg[k] <= '{
                pixel: src[k].pixel,
                sum:   src[k].sum,
                rem_r: step_r[SUM_W-1:0],
                rem_g: step_g[SUM_W-1:0],
                q_r:   {src[k].q_r[Q_W-2:0], step_r[SUM_W]},
                q_g:   {src[k].q_g[Q_W-2:0], step_g[SUM_W]}
            };
        end
    end

    assign stage_out = '{
        valid: stg_valid[Q_W-1],
        pixel: stg[Q_W-1].pixel,
        r:     stg[Q_W-1].q_r,
        g:     stg[Q_W-1].q_g
    };

endmodule

`default_nettype wire

// File: logic/skin_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "skin_consts.svh"

module skin_classifier
    import pixel_pkg::*;
    import chroma_pkg::*;
(
    input  wire                iCLK,
    input  wire                iRST_N,
    input  wire chroma_stage_t stage_in,
    output pixel_t             pix_out,
    output logic               pix_valid
);

    localparam int FRAC = `SKIN_FRAC;

    fix_t         r_fix;
    fix_t         g_fix;
    class_stage_t s1_next;
    class_stage_t s1;

    fix_t         g_s1;
    fix_t         f1;
    fix_t         f2;
    fix_t         w;
    logic         skin;

    // Q12 product, arithmetic shift rounds toward minus infinity
    function automatic fix_t qmul(input fix_t a, input fix_t b);
        return (a * b) >>> FRAC;
    endfunction

    assign r_fix = fix_t'(stage_in.r);
    assign g_fix = fix_t'(stage_in.g);

    // Stage one, squares and linear terms
    always_comb begin
        s1_next.valid  = stage_in.valid;
        s1_next.pixel  = stage_in.pixel;
        s1_next.r      = stage_in.r;
        s1_next.g      = stage_in.g;
        s1_next.r2     = qmul(r_fix, r_fix);
        s1_next.g2     = qmul(g_fix, g_fix);
        s1_next.r_lin1 = qmul(fix_t'(`SKIN_F1_B), r_fix);
        s1_next.r_lin2 = qmul(fix_t'(`SKIN_F2_B), r_fix);
        s1_next.rg_lin = qmul(fix_t'(`SKIN_W_K), r_fix + g_fix);
    end

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            s1 <= '0;
        end else begin
            s1 <= s1_next;
        end
    end

    // Stage two, bounds and distance
    assign g_s1 = fix_t'(s1.g);
    assign f1   = qmul(fix_t'(`SKIN_F1_A), s1.r2) + s1.r_lin1 + fix_t'(`SKIN_F1_C);
    assign f2   = qmul(fix_t'(`SKIN_F2_A), s1.r2) + s1.r_lin2 + fix_t'(`SKIN_F2_C);
    assign w    = s1.r2 + s1.g2 + s1.rg_lin + fix_t'(`SKIN_W_C);

    // A zero channel sum gives r = g = 0, and f2(0) is positive,
    // so the g > f2 test already rejects it
    assign skin = (f1 > g_s1) && (g_s1 > f2) && (w > fix_t'(`SKIN_W_MIN));

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= s1.valid;
        end
    end

    always_ff @(posedge iCLK) begin
        pix_out <= skin ? s1.pixel : '0;   // black when not skin
    end

endmodule

`default_nettype wire

// File: logic/credit_out_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "skin_consts.svh"

module credit_out_queue
    import pixel_pkg::*;
(
    input  wire         iCLK,
    input  wire         iRST_N,
    input  wire pixel_t pix_in,
    input  wire         pix_in_valid,
    input  wire         pix_out_credit,
    output pixel_t      pix_out,
    output logic        pix_out_valid,
    output logic        pix_in_credit
);

    localparam int DEPTH = `SKIN_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = `SKIN_CREDIT_W;

    pixel_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CNT_W-1:0] credits;
    logic             pop;
    logic             credit_full;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Send only with a queued pixel and a held downstream credit
    assign pop         = (fill != '0) && (credits != '0);
    assign credit_full = (credits == '1);

    // Upstream credits keep the queue from overflowing
    always_ff @(posedge iCLK) begin
        if (pix_in_valid) begin
            mem[wr_ptr] <= pix_in;
        end
    end

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (pix_in_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fill <= fill + CNT_W'(pix_in_valid) - CNT_W'(pop);
        end
    end

    // Downstream credit counter, saturates at its maximum
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            credits <= '0;
        end else begin
            case ({pix_out_credit, pop})
                2'b10: begin
                    if (!credit_full) begin
                        credits <= credits + 1'b1;
                    end
                end
                2'b01: credits <= credits - 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Each transfer frees one slot, so return one upstream credit
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            pix_out_valid <= 1'b0;
            pix_in_credit <= 1'b0;
        end else begin
            pix_out_valid <= pop;
            pix_in_credit <= pop;
        end
    end

    always_ff @(posedge iCLK) begin
        if (pop) begin
            pix_out <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: logic/skin_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module skin_filter_top
    import pixel_pkg::*;
    import chroma_pkg::*;
(
    input  wire         iCLK,
    input  wire         iRST_N,
    input  wire pixel_t pix_in,
    input  wire         pix_in_valid,
    output logic        pix_in_credit,
    output pixel_t      pix_out,
    output logic        pix_out_valid,
    input  wire         pix_out_credit
);

    // Divider to classifier
    chroma_stage_t div_stage;

    // Classifier to output queue
    pixel_t        cls_pix;
    logic          cls_valid;

    // Channel sum and r, g quotients, 14 cycles
    chroma_divider u_divider (
        .iCLK         (iCLK),
        .iRST_N       (iRST_N),
        .pix_in       (pix_in),
        .pix_in_valid (pix_in_valid),
        .stage_out    (div_stage)
    );

    // Bounds test and masking, 2 cycles
    skin_classifier u_classifier (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .stage_in  (div_stage),
        .pix_out   (cls_pix),
        .pix_valid (cls_valid)
    );

    // Credit flow control on both sides
    credit_out_queue u_queue (
        .iCLK           (iCLK),
        .iRST_N         (iRST_N),
        .pix_in         (cls_pix),
        .pix_in_valid   (cls_valid),
        .pix_out_credit (pix_out_credit),
        .pix_out        (pix_out),
        .pix_out_valid  (pix_out_valid),
        .pix_in_credit  (pix_in_credit)
    );

endmodule

`default_nettype wire

// File: bench/skin_model_pkg.sv
`default_nettype none

`include "skin_consts.svh"

package skin_model_pkg;

    import pixel_pkg::*;

    localparam longint SCALE = longint'(1) << `SKIN_FRAC;

    // Q12 product, floor of a*b/4096 for either sign
    function automatic int q12_mul(input int a, input int b);
        longint prod;
        prod = longint'(a) * longint'(b);
        if (prod >= 0) begin
            return int'(prod / SCALE);
        end
        return -int'((-prod + SCALE - 1) / SCALE);
    endfunction

    // Expected output pixel for one input pixel
    function automatic pixel_t expected_pixel(input pixel_t p);
        int s;
        int r;
        int g;
        int r2;
        int g2;
        int f1;
        int f2;
        int w;
        s = int'(p.red) + int'(p.green) + int'(p.blue);
        // No chromaticity for a black pixel, never skin
        if (s == 0) begin
            return '0;
        end
        r  = int'((longint'(p.red) * SCALE) / s);
        g  = int'((longint'(p.green) * SCALE) / s);
        r2 = q12_mul(r, r);
        g2 = q12_mul(g, g);
        f1 = q12_mul(`SKIN_F1_A, r2) + q12_mul(`SKIN_F1_B, r) + `SKIN_F1_C;
        f2 = q12_mul(`SKIN_F2_A, r2) + q12_mul(`SKIN_F2_B, r) + `SKIN_F2_C;
        w  = r2 + g2 + q12_mul(`SKIN_W_K, r + g) + `SKIN_W_C;
        if ((f1 > g) && (g > f2) && (w > `SKIN_W_MIN)) begin
            return p;
        end
        return '0;
    endfunction

endpackage

`default_nettype wire

// File: bench/skin_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "skin_consts.svh"

module skin_filter_tb
    import pixel_pkg::*;
    import skin_model_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic   iCLK;
    logic   iRST_N;
    pixel_t pix_in;
    logic   pix_in_valid;
    logic   pix_in_credit;
    pixel_t pix_out;
    logic   pix_out_valid;
    logic   pix_out_credit;

    integer seed = 5745;
    pixel_t exp_q[$];
    int     up_credits;
    int     grants_given;
    int     credits_seen;
    int     outputs_seen;
    int     in_credit_total;
    int     errors;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    string  cur_test;

    skin_filter_top dut_i (
        .iCLK           (iCLK),
        .iRST_N         (iRST_N),
        .pix_in         (pix_in),
        .pix_in_valid   (pix_in_valid),
        .pix_in_credit  (pix_in_credit),
        .pix_out        (pix_out),
        .pix_out_valid  (pix_out_valid),
        .pix_out_credit (pix_out_credit)
    );

    initial begin
        iCLK = 1'b0;
        forever #2 iCLK = ~iCLK;
    end

    // Scoreboard and credit bookkeeping on the rising edge
    always @(posedge iCLK) begin
        pixel_t expected;
        if (iRST_N) begin
            if (pix_in_credit) begin
                up_credits++;
                in_credit_total++;
            end
            if (pix_out_valid) begin
                assert (credits_seen > outputs_seen) else begin
                    $display("Output sent without a granted credit in test %s", cur_test);
                    errors++;
                end
                assert (exp_q.size() > 0) else begin
                    $display("Output appeared with no pixel outstanding in test %s", cur_test);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    assert (pix_out == expected) else begin
                        $display("CHECK FAILED %s: pix_out expected %h actual %h",
                                 cur_test, expected, pix_out);
                        errors++;
                    end
                end
                outputs_seen++;
            end
            if (pix_out_credit) begin
                credits_seen++;
            end
        end
    end

    function automatic logic chance(input int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    function automatic pixel_t random_pixel();
        logic [31:0] bits;
        pixel_t      p;
        bits = $random(seed);
        p    = bits[29:0];
        // Half of them ordered red >= green >= blue to land closer to skin tones
        if (chance(50)) begin
            p.green = chan_t'({$random(seed)} % (p.red + 1));
            p.blue  = chan_t'({$random(seed)} % (p.green + 1));
        end
        return p;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s in test %s", what, cur_test);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic expect_low(input string what, input logic actual);
        assert (actual == 1'b0) else begin
            $display("CHECK FAILED %s: %s expected 0 actual %b", cur_test, what, actual);
            errors++;
        end
    endtask

    // One clock of stimulus driven 1 ns after the edge
    // A credit is granted only for a pixel not yet covered by one
    task automatic drive_cycle(input logic valid, input pixel_t pix, input logic may_grant);
        logic grant;
        @(posedge iCLK);
        #1;
        if (valid) begin
            exp_q.push_back(expected_pixel(pix));
            up_credits--;
        end
        grant          = may_grant && ((grants_given - outputs_seen) < exp_q.size());
        pix_in_valid   = valid;
        pix_in         = pix;
        pix_out_credit = grant;
        if (grant) begin
            grants_given++;
        end
    endtask

    task automatic send_pixel(input pixel_t pix, input int grant_pct);
        int waited;
        waited = 0;
        while (up_credits == 0) begin
            if (waited == WAIT_LIMIT) begin
                abort_on_timeout("an upstream credit");
            end
            drive_cycle(1'b0, '0, chance(grant_pct));
            waited++;
        end
        drive_cycle(1'b1, pix, chance(grant_pct));
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            if (waited == WAIT_LIMIT) begin
                abort_on_timeout("the pipeline to drain");
            end
            drive_cycle(1'b0, '0, 1'b1);
            waited++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    initial begin
        pixel_t red;
        pix_in          = '0;
        pix_in_valid    = 1'b0;
        pix_out_credit  = 1'b0;
        iRST_N          = 1'b0;
        up_credits      = `SKIN_QUEUE_DEPTH;
        grants_given    = 0;
        credits_seen    = 0;
        outputs_seen    = 0;
        in_credit_total = 0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        cur_test        = "reset";
        repeat (2) @(posedge iCLK);
        #1;
        iRST_N = 1'b1;

        begin_test("reset_idle");
        repeat (20) begin
            drive_cycle(1'b0, '0, 1'b0);
            expect_low("pix_out_valid", pix_out_valid);
            expect_low("pix_in_credit", pix_in_credit);
        end
        end_test();

        // Pure red sits inside both bounds, so it passes unchanged
        begin_test("corner_pixels");
        red = '{red: 10'd1023, green: 10'd0, blue: 10'd0};
        assert (expected_pixel(red) == red) else begin
            $display("CHECK FAILED %s: model red expected %h actual %h",
                     cur_test, red, expected_pixel(red));
            errors++;
        end
        send_pixel('0, 100);
        send_pixel(red, 100);
        drain_outputs();
        end_test();

        begin_test("random_stream");
        repeat (300) begin
            send_pixel(random_pixel(), 50);
            if (chance(30)) begin
                drive_cycle(1'b0, '0, chance(50));
            end
        end
        drain_outputs();
        end_test();

        // Queue fills and nothing comes back until credits arrive
        begin_test("back_pressure");
        repeat (`SKIN_QUEUE_DEPTH) begin
            send_pixel(random_pixel(), 0);
        end
        repeat (40) begin
            drive_cycle(1'b0, '0, 1'b0);
            expect_low("pix_out_valid", pix_out_valid);
            expect_low("pix_in_credit", pix_in_credit);
        end
        assert (up_credits == 0) else begin
            $display("CHECK FAILED %s: upstream credits expected 0 actual %0d",
                     cur_test, up_credits);
            errors++;
        end
        drain_outputs();
        end_test();

        begin_test("credit_accounting");
        assert (in_credit_total == outputs_seen) else begin
            $display("CHECK FAILED %s: upstream credit pulses expected %0d actual %0d",
                     cur_test, outputs_seen, in_credit_total);
            errors++;
        end
        assert (up_credits == `SKIN_QUEUE_DEPTH) else begin
            $display("CHECK FAILED %s: upstream credits expected %0d actual %0d",
                     cur_test, `SKIN_QUEUE_DEPTH, up_credits);
            errors++;
        end
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if ((tests_failed == 0) && (errors == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: skin_filter.f
+incdir+include
logic/pixel_pkg.sv
logic/chroma_pkg.sv
logic/chroma_divider.sv
logic/skin_classifier.sv
logic/credit_out_queue.sv
logic/skin_filter_top.sv
bench/skin_model_pkg.sv
bench/skin_filter_tb.sv

// File: Bender.yml
package:
  name: skin_filter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/pixel_pkg.sv
      - logic/chroma_pkg.sv
      - logic/chroma_divider.sv
      - logic/skin_classifier.sv
      - logic/credit_out_queue.sv
      - logic/skin_filter_top.sv
      - target: test
        include_dirs:
          - include
        files:
          - bench/skin_model_pkg.sv
          - bench/skin_filter_tb.sv
